// File: project.f
+incdir+bench
rtl/alu_pkg.sv
rtl/operand_stage.sv
rtl/arith_unit.sv
rtl/logic_unit.sv
rtl/result_stage.sv
rtl/alu_top.sv
bench/alu_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --timing --assert
TOP      := alu_tb
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/alu_model.svh
`ifndef alu_model_svh
`define alu_model_svh

// operand rule and command legality, taken from the command tables
function automatic logic model_operand_err(input alu_mode_e m,
                                           input logic [cmd_width-1:0] c,
                                           input operand_sel_e sel);
    logic legal;
    logic a_only;
    logic b_only;
    if (m == mode_arith) begin
        legal  = c <= 4'd8;
        a_only = (c == cmd_inc_a) || (c == cmd_dec_a);
        b_only = (c == cmd_inc_b) || (c == cmd_dec_b);
    end else begin
        legal  = c <= 4'd13;
        a_only = (c == cmd_not_a) || (c == cmd_shr1_a) || (c == cmd_shl1_a);
        b_only = (c == cmd_not_b) || (c == cmd_shr1_b) || (c == cmd_shl1_b);
    end
    if (!legal) begin
        return 1'b1;
    end
    if (a_only) begin
        return sel != sel_a;
    end
    if (b_only) begin
        return sel != sel_b;
    end
    return sel == sel_none;
endfunction

// packed as {res, cout, oflow, g, l, e, err}
function automatic logic [2*data_width+5:0] model_predict(input alu_mode_e m,
                                                          input logic [cmd_width-1:0] c,
                                                          input operand_sel_e sel,
                                                          input logic [data_width-1:0] opa_in,
                                                          input logic [data_width-1:0] opb_in,
                                                          input logic cin_in);
    logic [data_width-1:0]   a;
    logic [data_width-1:0]   b;
    logic [data_width-1:0]   lo;
    logic [2*data_width-1:0] ax;
    logic [2*data_width-1:0] bx;
    logic [2*data_width-1:0] cx;
    logic [2*data_width-1:0] r;
    logic                    cy;
    logic                    ov;
    logic                    gt;
    logic                    lt;
    logic                    eq;
    logic                    er;
    int                      amt;
    int                      i;
    a  = sel[0] ? opa_in : '0;
    b  = sel[1] ? opb_in : '0;
    ax = {{data_width{1'b0}}, a};
    bx = {{data_width{1'b0}}, b};
    cx = {{(2*data_width-1){1'b0}}, cin_in};
    r  = '0;
    lo = '0;
    {cy, ov, gt, lt, eq, er} = 6'b0;
    if (model_operand_err(m, c, sel)) begin
        return {r, 6'b000001};
    end
    if (m == mode_arith) begin
        case (c)
            cmd_add:     r = ax + bx;
            cmd_sub:     r = ax - bx;
            cmd_add_cin: r = ax + bx + cx;
            cmd_sub_cin: r = ax - bx - cx;
            cmd_inc_a:   r = ax + 1;
            cmd_dec_a:   r = ax - 1;
            cmd_inc_b:   r = bx + 1;
            cmd_dec_b:   r = bx - 1;
            default:     r = '0;
        endcase
        if (c == cmd_add || c == cmd_add_cin || c == cmd_inc_a || c == cmd_inc_b) begin
            cy = r[data_width];
        end
        if (c == cmd_sub || c == cmd_sub_cin) begin
            ov = a < b;
        end
        if (c == cmd_dec_a) begin
            ov = a == '0;
        end
        if (c == cmd_dec_b) begin
            ov = b == '0;
        end
        if (c == cmd_cmp) begin
            gt = a > b;
            lt = a < b;
            eq = a == b;
        end
    end else begin
        case (c)
            cmd_and:    lo = a & b;
            cmd_nand:   lo = ~(a & b);
            cmd_or:     lo = a | b;
            cmd_nor:    lo = ~(a | b);
            cmd_xor:    lo = a ^ b;
            cmd_xnor:   lo = ~(a ^ b);
            cmd_not_a:  lo = ~a;
            cmd_not_b:  lo = ~b;
            cmd_shr1_a: lo = a >> 1;
            cmd_shl1_a: lo = a << 1;
            cmd_shr1_b: lo = b >> 1;
            cmd_shl1_b: lo = b << 1;
            default:    lo = '0;
        endcase
        // rotate one position at a time
        if (c == cmd_rol || c == cmd_ror) begin
            lo  = a;
            amt = int'(b) % data_width;
            for (i = 0; i < amt; i++) begin
                if (c == cmd_rol) begin
                    lo = {lo[data_width-2:0], lo[data_width-1]};
                end else begin
                    lo = {lo[0], lo[data_width-1:1]};
                end
            end
            er = (b >> ($clog2(data_width) + 1)) != '0;
        end
        r = {{data_width{1'b0}}, lo};
    end
    return {r, cy, ov, gt, lt, eq, er};
endfunction

`endif

// File: bench/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
    import alu_pkg::*;

    localparam int data_width   = 8;
    localparam int num_tests    = 3000;
    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;

    `include "alu_model.svh"

    logic                    clk;
    logic                    rst;
    logic                    ce;
    alu_mode_e               mode;
    logic [cmd_width-1:0]    cmd;
    operand_sel_e            inp_valid;
    logic [data_width-1:0]   opa;
    logic [data_width-1:0]   opb;
    logic                    cin;
    logic [2*data_width-1:0] res;
    logic                    cout;
    logic                    oflow;
    logic                    g;
    logic                    l;
    logic                    e;
    logic                    err;
    logic                    res_valid;

    logic [2*data_width-1:0] exp_res_q[$];
    logic [5:0]              exp_flags_q[$];
    int                      exp_cycle_q[$];
    logic [2*data_width-1:0] last_res;
    logic [5:0]              last_flags;
    logic [31:0]             rng_state;
    int                      cycle;

    alu_top #(.data_width(data_width)) i_dut (
        .clk       (clk),
        .rst       (rst),
        .ce        (ce),
        .mode      (mode),
        .cmd       (cmd),
        .inp_valid (inp_valid),
        .opa       (opa),
        .opb       (opb),
        .cin       (cin),
        .res       (res),
        .cout      (cout),
        .oflow     (oflow),
        .g         (g),
        .l         (l),
        .e         (e),
        .err       (err),
        .res_valid (res_valid)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_res(input logic [2*data_width-1:0] got,
                             input logic [2*data_width-1:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Error: res expected 0x%h, got 0x%h at cycle %0d",
                                exp, got, cycle));
        end
    endtask

    task automatic check_one_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("Error: %s expected 0x%h, got 0x%h at cycle %0d",
                                name, exp, got, cycle));
        end
    endtask

    // bit order is cout, oflow, g, l, e, err
    task automatic check_flags(input logic [5:0] got, input logic [5:0] exp);
        check_one_flag("cout", got[5], exp[5]);
        check_one_flag("oflow", got[4], exp[4]);
        check_one_flag("g", got[3], exp[3]);
        check_one_flag("l", got[2], exp[2]);
        check_one_flag("e", got[1], exp[1]);
        check_one_flag("err", got[0], exp[0]);
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("Error: res_valid expected 0x%h, got 0x%h at cycle %0d",
                                exp, got, cycle));
        end
    endtask

    task automatic check_outputs();
        logic       due;
        logic [5:0] flags_now;
        due = 1'b0;
        if (exp_cycle_q.size() > 0) begin
            due = exp_cycle_q[0] == cycle - 2;
        end
        flags_now = {cout, oflow, g, l, e, err};
        check_valid(res_valid, due);
        if (due) begin
            check_res(res, exp_res_q.pop_front());
            check_flags(flags_now, exp_flags_q.pop_front());
            void'(exp_cycle_q.pop_front());
            last_res   = res;
            last_flags = flags_now;
        end else begin
            // no result this cycle, outputs hold
            check_res(res, last_res);
            check_flags(flags_now, last_flags);
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycle = cycle + 1;
        check_outputs();
    endtask

    task automatic drive_random();
        logic [31:0]             r;
        logic [31:0]             s;
        logic [2*data_width+5:0] pred;
        rng_state = xorshift(rng_state);
        r         = rng_state;
        rng_state = xorshift(rng_state);
        s         = rng_state;
        ce        = r[1:0] != 2'b00;
        mode      = alu_mode_e'(r[2]);
        cmd       = r[6:3];
        inp_valid = operand_sel_e'(r[8:7]);
        cin       = r[9];
        opa       = s[data_width-1:0];
        opb       = s[2*data_width-1:data_width];
        // small b keeps about half the rotates in range
        if (r[10]) begin
            opb[data_width-1:4] = '0;
        end
        if (r[13:11] == 3'd0) begin
            opb = opa;
        end
        if (r[16:14] == 3'd0) begin
            opa = '1;
        end
        if (r[16:14] == 3'd1) begin
            opa = '0;
        end
        if (r[19:17] == 3'd0) begin
            opb = '0;
        end
        if (ce) begin
            pred = model_predict(mode, cmd, inp_valid, opa, opb, cin);
            exp_res_q.push_back(pred[2*data_width+5:6]);
            exp_flags_q.push_back(pred[5:0]);
            exp_cycle_q.push_back(cycle);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((num_tests * 3 + reset_cycles) * clk_period);
        fail_stop("watchdog timeout, the test did not finish in time");
    end

    initial begin
        rst        = 1'b1;
        ce         = 1'b0;
        mode       = mode_logic;
        cmd        = '0;
        inp_valid  = sel_none;
        opa        = '0;
        opb        = '0;
        cin        = 1'b0;
        rng_state  = 32'd25637;
        cycle      = 0;
        last_res   = '0;
        last_flags = '0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        // idle after reset, everything must read zero
        repeat (8) tick();
        repeat (num_tests) begin
            drive_random();
            tick();
        end
        ce = 1'b0;
        repeat (4) tick();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top #(
    parameter int data_width = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ce,
    input  alu_pkg::alu_mode_e            mode,
    input  logic [alu_pkg::cmd_width-1:0] cmd,
    input  alu_pkg::operand_sel_e         inp_valid,
    input  logic [data_width-1:0]         opa,
    input  logic [data_width-1:0]         opb,
    input  logic                          cin,
    output logic [2*data_width-1:0]       res,
    output logic                          cout,
    output logic                          oflow,
    output logic                          g,
    output logic                          l,
    output logic                          e,
    output logic                          err,
    output logic                          res_valid
);
    import alu_pkg::*;

    logic                    s1_valid;
    alu_mode_e               s1_mode;
    logic [cmd_width-1:0]    s1_cmd;
    logic [data_width-1:0]   s1_a;
    logic [data_width-1:0]   s1_b;
    logic                    s1_cin;
    logic                    s1_operand_err;

    logic [2*data_width-1:0] arith_res;
    logic                    arith_cout;
    logic                    arith_oflow;
    logic                    arith_g;
    logic                    arith_l;
    logic                    arith_e;
    logic [2*data_width-1:0] logic_res;
    logic                    logic_rot_err;

    operand_stage #(.data_width(data_width)) i_operand_stage (
        .clk            (clk),
        .rst            (rst),
        .ce             (ce),
        .mode           (mode),
        .cmd            (cmd),
        .inp_valid      (inp_valid),
        .opa            (opa),
        .opb            (opb),
        .cin            (cin),
        .s1_valid       (s1_valid),
        .s1_mode        (s1_mode),
        .s1_cmd         (s1_cmd),
        .s1_a           (s1_a),
        .s1_b           (s1_b),
        .s1_cin         (s1_cin),
        .s1_operand_err (s1_operand_err)
    );

    arith_unit #(.data_width(data_width)) i_arith_unit (
        .s1_cmd      (s1_cmd),
        .s1_a        (s1_a),
        .s1_b        (s1_b),
        .s1_cin      (s1_cin),
        .arith_res   (arith_res),
        .arith_cout  (arith_cout),
        .arith_oflow (arith_oflow),
        .arith_g     (arith_g),
        .arith_l     (arith_l),
        .arith_e     (arith_e)
    );

    logic_unit #(.data_width(data_width)) i_logic_unit (
        .s1_cmd        (s1_cmd),
        .s1_a          (s1_a),
        .s1_b          (s1_b),
        .logic_res     (logic_res),
        .logic_rot_err (logic_rot_err)
    );

    result_stage #(.data_width(data_width)) i_result_stage (
        .clk            (clk),
        .rst            (rst),
        .s1_valid       (s1_valid),
        .s1_mode        (s1_mode),
        .s1_operand_err (s1_operand_err),
        .arith_res      (arith_res),
        .arith_cout     (arith_cout),
        .arith_oflow    (arith_oflow),
        .arith_g        (arith_g),
        .arith_l        (arith_l),
        .arith_e        (arith_e),
        .logic_res      (logic_res),
        .logic_rot_err  (logic_rot_err),
        .res            (res),
        .cout           (cout),
        .oflow          (oflow),
        .g              (g),
        .l              (l),
        .e              (e),
        .err            (err),
        .res_valid      (res_valid)
    );

endmodule

`default_nettype wire

// File: rtl/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
    parameter int data_width = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s1_valid,
    input  alu_pkg::alu_mode_e      s1_mode,
    input  logic                    s1_operand_err,
    input  logic [2*data_width-1:0] arith_res,
    input  logic                    arith_cout,
    input  logic                    arith_oflow,
    input  logic                    arith_g,
    input  logic                    arith_l,
    input  logic                    arith_e,
    input  logic [2*data_width-1:0] logic_res,
    input  logic                    logic_rot_err,
    output logic [2*data_width-1:0] res,
    output logic                    cout,
    output logic                    oflow,
    output logic                    g,
    output logic                    l,
    output logic                    e,
    output logic                    err,
    output logic                    res_valid
);
    import alu_pkg::*;

    // set when err came from a rotate range and res carries data
    logic rot_err_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res       <= '0;
            cout      <= 1'b0;
            oflow     <= 1'b0;
            g         <= 1'b0;
            l         <= 1'b0;
            e         <= 1'b0;
            err       <= 1'b0;
            rot_err_q <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid;
            if (s1_valid) begin
                if (s1_operand_err) begin
                    res       <= '0;
                    {cout, oflow, g, l, e} <= '0;
                    err       <= 1'b1;
                    rot_err_q <= 1'b0;
                end else if (s1_mode == mode_arith) begin
                    res       <= arith_res;
                    cout      <= arith_cout;
                    oflow     <= arith_oflow;
                    g         <= arith_g;
                    l         <= arith_l;
                    e         <= arith_e;
                    err       <= 1'b0;
                    rot_err_q <= 1'b0;
                end else begin
                    res       <= logic_res;
                    {cout, oflow, g, l, e} <= '0;
                    err       <= logic_rot_err;
                    rot_err_q <= logic_rot_err;
                end
            end
        end
    end

    a_cmp_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0({g, l, e})
    );

    a_err_zero_res: assert property (
        @(posedge clk) disable iff (rst) (res_valid && err && !rot_err_q) |-> res == '0
    );

endmodule

`default_nettype wire

// File: rtl/logic_unit.sv
`timescale 1ns/1ps
`default_nettype none

module logic_unit #(
    parameter int data_width = 8
) (
    input  logic [alu_pkg::cmd_width-1:0] s1_cmd,
    input  logic [data_width-1:0]         s1_a,
    input  logic [data_width-1:0]         s1_b,
    output logic [2*data_width-1:0]       logic_res,
    output logic                          logic_rot_err
);
    import alu_pkg::*;

    localparam int amt_width = $clog2(data_width);
    localparam logic [amt_width:0] width_l = data_width[amt_width:0];

    logic [data_width-1:0] lo;
    logic [amt_width-1:0]  rot_amt;
    logic [amt_width:0]    rev_amt;
    logic                  b_out_of_range;
    logic [data_width-1:0] rol_val;
    logic [data_width-1:0] ror_val;

    assign rot_amt = s1_b[amt_width-1:0];
    assign rev_amt = width_l - {1'b0, rot_amt};

    // bit amt_width of b is ignored, higher bits flag the error
    assign b_out_of_range = |(s1_b >> (amt_width + 1));

    assign rol_val = (s1_a << rot_amt) | (s1_a >> rev_amt);
    assign ror_val = (s1_a >> rot_amt) | (s1_a << rev_amt);

    always_comb begin
        lo            = '0;
        logic_rot_err = 1'b0;
        case (logic_cmd_e'(s1_cmd))
            cmd_and:    lo = s1_a & s1_b;
            cmd_nand:   lo = ~(s1_a & s1_b);
            cmd_or:     lo = s1_a | s1_b;
            cmd_nor:    lo = ~(s1_a | s1_b);
            cmd_xor:    lo = s1_a ^ s1_b;
            cmd_xnor:   lo = ~(s1_a ^ s1_b);
            cmd_not_a:  lo = ~s1_a;
            cmd_not_b:  lo = ~s1_b;
            cmd_shr1_a: lo = s1_a >> 1;
            cmd_shl1_a: lo = s1_a << 1;
            cmd_shr1_b: lo = s1_b >> 1;
            cmd_shl1_b: lo = s1_b << 1;
            cmd_rol: begin
                lo            = rol_val;
                logic_rot_err = b_out_of_range;
            end
            cmd_ror: begin
                lo            = ror_val;
                logic_rot_err = b_out_of_range;
            end
            default: lo = '0;
        endcase
    end

    assign logic_res = {{data_width{1'b0}}, lo};

endmodule

`default_nettype wire

// File: rtl/arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module arith_unit #(
    parameter int data_width = 8
) (
    input  logic [alu_pkg::cmd_width-1:0] s1_cmd,
    input  logic [data_width-1:0]         s1_a,
    input  logic [data_width-1:0]         s1_b,
    input  logic                          s1_cin,
    output logic [2*data_width-1:0]       arith_res,
    output logic                          arith_cout,
    output logic                          arith_oflow,
    output logic                          arith_g,
    output logic                          arith_l,
    output logic                          arith_e
);
    import alu_pkg::*;

    localparam int res_width = 2 * data_width;

    logic [res_width-1:0] a_ext;
    logic [res_width-1:0] b_ext;
    logic [res_width-1:0] cin_ext;
    logic [res_width-1:0] one;

    assign a_ext   = {{data_width{1'b0}}, s1_a};
    assign b_ext   = {{data_width{1'b0}}, s1_b};
    assign cin_ext = {{(res_width-1){1'b0}}, s1_cin};
    assign one     = {{(res_width-1){1'b0}}, 1'b1};

    always_comb begin
        arith_res   = '0;
        arith_cout  = 1'b0;
        arith_oflow = 1'b0;
        arith_g     = 1'b0;
        arith_l     = 1'b0;
        arith_e     = 1'b0;
        case (arith_cmd_e'(s1_cmd))
            cmd_add: begin
                arith_res  = a_ext + b_ext;
                arith_cout = arith_res[data_width];
            end
            cmd_sub: begin
                arith_res   = a_ext - b_ext;
                arith_oflow = s1_a < s1_b;
            end
            cmd_add_cin: begin
                arith_res  = a_ext + b_ext + cin_ext;
                arith_cout = arith_res[data_width];
            end
            cmd_sub_cin: begin
                arith_res   = a_ext - b_ext - cin_ext;
                arith_oflow = s1_a < s1_b;
            end
            cmd_inc_a: begin
                arith_res  = a_ext + one;
                arith_cout = arith_res[data_width];
            end
            cmd_dec_a: begin
                arith_res   = a_ext - one;
                arith_oflow = s1_a == '0;
            end
            cmd_inc_b: begin
                arith_res  = b_ext + one;
                arith_cout = arith_res[data_width];
            end
            cmd_dec_b: begin
                arith_res   = b_ext - one;
                arith_oflow = s1_b == '0;
            end
            // unsigned compare, result stays zero
            cmd_cmp: begin
                arith_g = s1_a > s1_b;
                arith_l = s1_a < s1_b;
                arith_e = s1_a == s1_b;
            end
            default: arith_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage #(
    parameter int data_width = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ce,
    input  alu_pkg::alu_mode_e            mode,
    input  logic [alu_pkg::cmd_width-1:0] cmd,
    input  alu_pkg::operand_sel_e         inp_valid,
    input  logic [data_width-1:0]         opa,
    input  logic [data_width-1:0]         opb,
    input  logic                          cin,
    output logic                          s1_valid,
    output alu_pkg::alu_mode_e            s1_mode,
    output logic [alu_pkg::cmd_width-1:0] s1_cmd,
    output logic [data_width-1:0]         s1_a,
    output logic [data_width-1:0]         s1_b,
    output logic                          s1_cin,
    output logic                          s1_operand_err
);
    import alu_pkg::*;

    logic legal;
    logic need_a_only;
    logic need_b_only;
    logic operand_err;

    always_comb begin
        legal       = 1'b0;
        need_a_only = 1'b0;
        need_b_only = 1'b0;
        if (mode == mode_arith) begin
            case (arith_cmd_e'(cmd))
                cmd_add, cmd_sub, cmd_add_cin, cmd_sub_cin, cmd_cmp: begin
                    legal = 1'b1;
                end
                cmd_inc_a, cmd_dec_a: begin
                    legal       = 1'b1;
                    need_a_only = 1'b1;
                end
                cmd_inc_b, cmd_dec_b: begin
                    legal       = 1'b1;
                    need_b_only = 1'b1;
                end
                default: legal = 1'b0;
            endcase
        end else begin
            case (logic_cmd_e'(cmd))
                cmd_and, cmd_nand, cmd_or, cmd_nor, cmd_xor, cmd_xnor,
                cmd_rol, cmd_ror: begin
                    legal = 1'b1;
                end
                cmd_not_a, cmd_shr1_a, cmd_shl1_a: begin
                    legal       = 1'b1;
                    need_a_only = 1'b1;
                end
                cmd_not_b, cmd_shr1_b, cmd_shl1_b: begin
                    legal       = 1'b1;
                    need_b_only = 1'b1;
                end
                default: legal = 1'b0;
            endcase
        end
    end

    // single-operand commands want exactly their operand, the rest want any
    assign operand_err = !legal
                       || (need_a_only && inp_valid != sel_a)
                       || (need_b_only && inp_valid != sel_b)
                       || (!need_a_only && !need_b_only && inp_valid == sel_none);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid       <= 1'b0;
            s1_mode        <= mode_logic;
            s1_cmd         <= '0;
            s1_operand_err <= 1'b0;
        end else begin
            s1_valid <= ce;
            if (ce) begin
                s1_mode        <= mode;
                s1_cmd         <= cmd;
                s1_operand_err <= operand_err;
            end
        end
    end

    // absent operands are captured as zero
    always_ff @(posedge clk) begin
        if (ce) begin
            s1_a   <= inp_valid[0] ? opa : '0;
            s1_b   <= inp_valid[1] ? opb : '0;
            s1_cin <= cin;
        end
    end

    a_issue_known: assert property (
        @(posedge clk) disable iff (rst) ce |-> !$isunknown({inp_valid, cmd, mode})
    );

endmodule

`default_nettype wire

// File: rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int cmd_width = 4;

    typedef enum logic {
        mode_logic = 1'b0,
        mode_arith = 1'b1
    } alu_mode_e;

    // codes 9 and up are illegal in arithmetic mode
    typedef enum logic [cmd_width-1:0] {
        cmd_add     = 4'd0,
        cmd_sub     = 4'd1,
        cmd_add_cin = 4'd2,
        cmd_sub_cin = 4'd3,
        cmd_inc_a   = 4'd4,
        cmd_dec_a   = 4'd5,
        cmd_inc_b   = 4'd6,
        cmd_dec_b   = 4'd7,
        cmd_cmp     = 4'd8
    } arith_cmd_e;

    typedef enum logic [cmd_width-1:0] {
        cmd_and    = 4'd0,
        cmd_nand   = 4'd1,
        cmd_or     = 4'd2,
        cmd_nor    = 4'd3,
        cmd_xor    = 4'd4,
        cmd_xnor   = 4'd5,
        cmd_not_a  = 4'd6,
        cmd_not_b  = 4'd7,
        cmd_shr1_a = 4'd8,
        cmd_shl1_a = 4'd9,
        cmd_shr1_b = 4'd10,
        cmd_shl1_b = 4'd11,
        cmd_rol    = 4'd12,
        cmd_ror    = 4'd13
    } logic_cmd_e;

    // bit 0 is operand a, bit 1 is operand b
    typedef enum logic [1:0] {
        sel_none = 2'b00,
        sel_a    = 2'b01,
        sel_b    = 2'b10,
        sel_both = 2'b11
    } operand_sel_e;

endpackage

`default_nettype wire
